// ==== source/cq_rx_pkg.sv ====
package cq_rx_pkg;

    ////////////////////
    // widths
    ////////////////////
    localparam int BEAT_W  = 256;            // cq stream data
    localparam int DW_W    = 32;
    localparam int HALF_W  = BEAT_W / 2;     // payload sits one half-beat up
    localparam int BEAT_DW = BEAT_W / DW_W;  // 8 dw per beat
    localparam int HALF_DW = HALF_W / DW_W;  // 4 dw per half
    localparam int LEN_W   = 11;             // dw count field
    localparam int ADDR_W  = 11;             // dw address into ep memory

    // request type codes, as found in the descriptor
    localparam logic [3:0] REQ_MEM_RD = 4'd0;
    localparam logic [3:0] REQ_MEM_WR = 4'd1;

    localparam int WINDOW_CYCLES_DEF = 25_000_000;  // 100 ms at 250 MHz

    ////////////////////
    // descriptor fields in the first beat
    ////////////////////
    localparam int ADDR_LSB = 2;    // dw aligned, byte bits dropped
    localparam int ADDR_MSB = 12;
    localparam int LEN_LSB  = 64;
    localparam int LEN_MSB  = 74;
    localparam int TYPE_LSB = 75;
    localparam int TYPE_MSB = 78;
    localparam int RID_LSB  = 80;   // requester id
    localparam int RID_MSB  = 95;
    localparam int TAG_LSB  = 96;
    localparam int TAG_MSB  = 103;
    localparam int TC_LSB   = 121;
    localparam int TC_MSB   = 123;
    localparam int ATTR_LSB = 124;
    localparam int ATTR_MSB = 126;
    localparam int PLD_LSB  = 128;  // dw0..3 of the header beat

    typedef struct packed {
        logic [BEAT_W-1:0] data;
        logic              last;
        logic [7:0]        be;    // first/last dw byte enables from tuser
    } cq_beat_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [2:0]        tc;
        logic [2:0]        attr;
        logic [LEN_W-1:0]  len;
        logic [15:0]       rid;
        logic [7:0]        tag;
        logic [7:0]        be;
    } rd_req_t;

    typedef logic [BEAT_W-1:0] fifo_word_t;  // low dw in low bits

    typedef enum logic [2:0] {
        WR_NONE,
        WR_SHORT,   // 1..4 dw, all in header beat
        WR_FIRST,   // header beat of long write, keep upper half
        WR_MERGE,   // kept half + new lower half
        WR_FLUSH    // leftover half after last beat
    } wr_op_t;

endpackage

// ==== source/cq_rx_fsm.sv ====
`timescale 1ns/1ps

module cq_rx_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 init_rst_i,
    input  cq_rx_pkg::cq_beat_t  cq_i,
    input  logic                 cq_valid_i,
    output logic                 cq_tready_o,
    input  logic                 compl_done_i,
    output logic                 req_compl_o,
    output cq_rx_pkg::rd_req_t   rd_req_o,
    input  logic                 fits_i,       // this beat ends the payload
    input  logic                 tail_i,       // nothing left in upper half
    output logic                 load_o,
    output logic                 step_o,
    output cq_rx_pkg::wr_op_t    op_o,
    output logic                 wr_beat_o,
    output logic                 pkt_done_o
);
    typedef enum logic [1:0] {ST_IDLE, ST_RD_WAIT, ST_WR_STREAM, ST_FLUSH} state_t;

    state_t                      state_q, state_d;
    logic                        in_pkt_q;    // set after first beat until last
    logic                        accept, sop;
    logic                        is_rd, is_wr;
    logic                        done_d;
    logic [cq_rx_pkg::LEN_W-1:0] len;

    assign cq_tready_o = (state_q == ST_IDLE) || (state_q == ST_WR_STREAM);
    assign accept      = cq_valid_i && cq_tready_o;
    assign sop         = accept && !in_pkt_q;
    assign len   = cq_i.data[cq_rx_pkg::LEN_MSB:cq_rx_pkg::LEN_LSB];
    assign is_rd = cq_i.data[cq_rx_pkg::TYPE_MSB:cq_rx_pkg::TYPE_LSB] == cq_rx_pkg::REQ_MEM_RD;
    assign is_wr = cq_i.data[cq_rx_pkg::TYPE_MSB:cq_rx_pkg::TYPE_LSB] == cq_rx_pkg::REQ_MEM_WR;

    assign req_compl_o = (state_q == ST_RD_WAIT);  // held until completion sent
    assign wr_beat_o   = accept && ((sop && is_wr) || (state_q == ST_WR_STREAM));

    ////////////////////
    // next state and steering
    ////////////////////
    always_comb begin
        state_d = state_q;
        op_o    = cq_rx_pkg::WR_NONE;
        load_o  = 1'b0;
        step_o  = 1'b0;
        done_d  = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (sop && is_rd && len == 1) begin
                    state_d = ST_RD_WAIT;  // other read lengths dropped
                end else if (sop && is_wr && len <= cq_rx_pkg::HALF_DW) begin
                    op_o   = cq_rx_pkg::WR_SHORT;
                    done_d = 1'b1;
                end else if (sop && is_wr) begin
                    op_o    = cq_rx_pkg::WR_FIRST;
                    load_o  = 1'b1;
                    state_d = ST_WR_STREAM;
                end
            end
            ST_RD_WAIT: begin
                if (compl_done_i) state_d = ST_IDLE;
            end
            ST_WR_STREAM: begin
                if (accept) begin
                    op_o   = cq_rx_pkg::WR_MERGE;
                    step_o = 1'b1;
                    if (fits_i) begin
                        state_d = tail_i ? ST_IDLE : ST_FLUSH;
                        done_d  = tail_i;
                    end
                end
            end
            ST_FLUSH: begin
                op_o    = cq_rx_pkg::WR_FLUSH;  // ready low this cycle
                done_d  = 1'b1;
                state_d = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= ST_IDLE;
            in_pkt_q   <= 1'b0;
            pkt_done_o <= 1'b0;
        end else begin
            state_q    <= init_rst_i ? ST_IDLE : state_d;
            pkt_done_o <= done_d;  // lines up with the registered fifo word
            if (accept) in_pkt_q <= !cq_i.last;
        end
    end

    // read fields, captured on the accepted start beat
    always_ff @(posedge clk) begin
        if (sop && is_rd && len == 1) begin
            rd_req_o.addr <= cq_i.data[cq_rx_pkg::ADDR_MSB:cq_rx_pkg::ADDR_LSB];
            rd_req_o.tc   <= cq_i.data[cq_rx_pkg::TC_MSB:cq_rx_pkg::TC_LSB];
            rd_req_o.attr <= cq_i.data[cq_rx_pkg::ATTR_MSB:cq_rx_pkg::ATTR_LSB];
            rd_req_o.len  <= len;
            rd_req_o.rid  <= cq_i.data[cq_rx_pkg::RID_MSB:cq_rx_pkg::RID_LSB];
            rd_req_o.tag  <= cq_i.data[cq_rx_pkg::TAG_MSB:cq_rx_pkg::TAG_LSB];
            rd_req_o.be   <= cq_i.be;
        end
    end

endmodule

// ==== source/wr_dw_counter.sv ====
`timescale 1ns/1ps

module wr_dw_counter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        load_i,  // header beat of a long write
    input  logic [cq_rx_pkg::LEN_W-1:0] len_i,
    input  logic                        step_i,  // one more beat merged
    output logic                        fits_o,
    output logic                        tail_o
);
    logic [cq_rx_pkg::LEN_W-1:0] rem_q;  // payload dws not yet seen

    ////////////////////
    // remaining count
    ////////////////////
    // header beat already carried dw0..3, later beats carry 8 each
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rem_q <= '0;
        end else if (load_i) begin
            rem_q <= len_i - cq_rx_pkg::LEN_W'(cq_rx_pkg::HALF_DW);
        end else if (step_i) begin
            if (fits_o) begin
                rem_q <= '0;  // payload done, no wrap
            end else begin
                rem_q <= rem_q - cq_rx_pkg::LEN_W'(cq_rx_pkg::BEAT_DW);
            end
        end
    end

    // current beat holds the rest of the payload
    assign fits_o = rem_q <= cq_rx_pkg::LEN_W'(cq_rx_pkg::BEAT_DW);

    // rest fits in the lower half, so no flush word
    assign tail_o = rem_q <= cq_rx_pkg::LEN_W'(cq_rx_pkg::HALF_DW);

endmodule

// ==== source/wr_realign.sv ====
`timescale 1ns/1ps

module wr_realign (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cq_rx_pkg::cq_beat_t   cq_i,
    input  cq_rx_pkg::wr_op_t     op_i,
    output logic                  fifo_wr_o,
    output cq_rx_pkg::fifo_word_t fifo_data_o
);
    logic [cq_rx_pkg::HALF_W-1:0] held_q;     // upper half of previous beat
    logic [cq_rx_pkg::LEN_W-1:0]  short_len;
    cq_rx_pkg::fifo_word_t        short_word;

    assign short_len = cq_i.data[cq_rx_pkg::LEN_MSB:cq_rx_pkg::LEN_LSB];

    ////////////////////
    // short write packing
    ////////////////////
    // dw0..N-1 down to the bottom, zeros above
    always_comb begin
        short_word = '0;
        for (int i = 0; i < cq_rx_pkg::HALF_DW; i++) begin
            if (i < short_len) begin
                short_word[i*cq_rx_pkg::DW_W +: cq_rx_pkg::DW_W] =
                    cq_i.data[cq_rx_pkg::PLD_LSB + i*cq_rx_pkg::DW_W +: cq_rx_pkg::DW_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fifo_wr_o <= 1'b0;
        end else begin
            // first beat only fills the holding half
            fifo_wr_o <= (op_i == cq_rx_pkg::WR_SHORT) ||
                         (op_i == cq_rx_pkg::WR_MERGE) ||
                         (op_i == cq_rx_pkg::WR_FLUSH);
        end
    end

    ////////////////////
    // word and held half
    ////////////////////
    always_ff @(posedge clk) begin
        case (op_i)
            cq_rx_pkg::WR_SHORT: fifo_data_o <= short_word;
            cq_rx_pkg::WR_FIRST: held_q <= cq_i.data[cq_rx_pkg::BEAT_W-1:cq_rx_pkg::HALF_W];
            cq_rx_pkg::WR_MERGE: begin
                // older dws low, newer dws high
                fifo_data_o <= {cq_i.data[cq_rx_pkg::HALF_W-1:0], held_q};
                held_q      <= cq_i.data[cq_rx_pkg::BEAT_W-1:cq_rx_pkg::HALF_W];
            end
            cq_rx_pkg::WR_FLUSH: fifo_data_o <= {{cq_rx_pkg::HALF_W{1'b0}}, held_q};
            default: ;  // idle, word holds
        endcase
    end

endmodule

// ==== source/tput_meter.sv ====
`timescale 1ns/1ps

module tput_meter #(
    parameter int WINDOW_CYCLES = cq_rx_pkg::WINDOW_CYCLES_DEF
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clear_i,    // restart window, drop partial count
    input  logic        wr_beat_i,  // accepted write beat this cycle
    output logic [31:0] count_o,
    output logic        valid_o
);
    localparam int TMR_W = $clog2(WINDOW_CYCLES + 1);

    logic [TMR_W-1:0] timer_q;  // 0 .. WINDOW_CYCLES-1
    logic [31:0]      beats_q;  // beats so far in this window
    logic             win_end;

    assign win_end = timer_q == TMR_W'(WINDOW_CYCLES - 1);

    ////////////////////
    // window timer
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n || clear_i) begin
            timer_q <= '0;
        end else if (win_end) begin
            timer_q <= '0;
        end else begin
            timer_q <= timer_q + 1'b1;
        end
    end

    ////////////////////
    // beat count and result
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beats_q <= '0;
            count_o <= '0;
            valid_o <= 1'b0;
        end else if (clear_i) begin
            beats_q <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= win_end;
            if (win_end) begin
                count_o <= beats_q + 32'(wr_beat_i);  // last cycle still counts
                beats_q <= '0;
            end else begin
                beats_q <= beats_q + 32'(wr_beat_i);
            end
        end
    end

endmodule

// ==== source/cq_rx_engine.sv ====
`timescale 1ns/1ps

module cq_rx_engine #(
    parameter int WINDOW_CYCLES = cq_rx_pkg::WINDOW_CYCLES_DEF
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  init_rst_i,
    // completer request stream
    input  cq_rx_pkg::cq_beat_t   cq_i,
    input  logic                  cq_valid_i,
    output logic                  cq_tready_o,
    // read handoff to completion sender
    output logic                  req_compl_o,
    input  logic                  compl_done_i,
    output cq_rx_pkg::rd_req_t    rd_req_o,
    // write payload to fifo
    output logic                  fifo_wr_o,
    output cq_rx_pkg::fifo_word_t fifo_data_o,
    output logic                  pkt_done_o,
    // throughput
    input  logic                  tput_clear_i,
    output logic [31:0]           tput_count_o,
    output logic                  tput_valid_o
);
    logic              fits, tail;
    logic              load, step;
    logic              wr_beat;
    cq_rx_pkg::wr_op_t op;

    cq_rx_fsm u_fsm (
        .clk(clk), .rst_n(rst_n), .init_rst_i(init_rst_i),
        .cq_i(cq_i), .cq_valid_i(cq_valid_i), .cq_tready_o(cq_tready_o),
        .compl_done_i(compl_done_i), .req_compl_o(req_compl_o), .rd_req_o(rd_req_o),
        .fits_i(fits), .tail_i(tail),
        .load_o(load), .step_o(step), .op_o(op),
        .wr_beat_o(wr_beat), .pkt_done_o(pkt_done_o)
    );

    // length taken straight off the header beat
    wr_dw_counter u_cnt (
        .clk(clk), .rst_n(rst_n),
        .load_i(load), .len_i(cq_i.data[cq_rx_pkg::LEN_MSB:cq_rx_pkg::LEN_LSB]),
        .step_i(step), .fits_o(fits), .tail_o(tail)
    );

    wr_realign u_align (
        .clk(clk), .rst_n(rst_n), .cq_i(cq_i), .op_i(op),
        .fifo_wr_o(fifo_wr_o), .fifo_data_o(fifo_data_o)
    );

    tput_meter #(
        .WINDOW_CYCLES(WINDOW_CYCLES)
    ) u_tput (
        .clk(clk), .rst_n(rst_n), .clear_i(tput_clear_i), .wr_beat_i(wr_beat),
        .count_o(tput_count_o), .valid_o(tput_valid_o)
    );

endmodule

// ==== test/cq_rx_cases.svh ====
`ifndef CQ_RX_CASES_SVH
`define CQ_RX_CASES_SVH

localparam int NUM_CASES = 11;
localparam int MAX_DW    = 32;

typedef struct packed {
    logic [3:0]  req_type;
    logic [10:0] len;       // dw count
    logic [10:0] addr;      // dw address
    logic [3:0]  words;     // fifo words expected
} case_row_t;

////////////////////
// stimulus table
////////////////////
string case_name [NUM_CASES] = '{
    "wr_1dw", "wr_2dw", "wr_3dw", "wr_4dw", "wr_8dw", "wr_12dw",
    "wr_16dw", "wr_20dw", "rd_1dw", "rd_2dw", "wr_after_rd"
};

case_row_t case_tab [NUM_CASES] = '{
    '{cq_rx_pkg::REQ_MEM_WR, 11'd1,  11'h010, 4'd1},
    '{cq_rx_pkg::REQ_MEM_WR, 11'd2,  11'h024, 4'd1},
    '{cq_rx_pkg::REQ_MEM_WR, 11'd3,  11'h031, 4'd1},
    '{cq_rx_pkg::REQ_MEM_WR, 11'd4,  11'h047, 4'd1},
    '{cq_rx_pkg::REQ_MEM_WR, 11'd8,  11'h100, 4'd1},   // ends on tail, no flush
    '{cq_rx_pkg::REQ_MEM_WR, 11'd12, 11'h180, 4'd2},   // flush word
    '{cq_rx_pkg::REQ_MEM_WR, 11'd16, 11'h200, 4'd2},
    '{cq_rx_pkg::REQ_MEM_WR, 11'd20, 11'h2c0, 4'd3},   // two merges plus flush
    '{cq_rx_pkg::REQ_MEM_RD, 11'd1,  11'h3a5, 4'd0},
    '{cq_rx_pkg::REQ_MEM_RD, 11'd2,  11'h05a, 4'd0},   // ignored length
    '{cq_rx_pkg::REQ_MEM_WR, 11'd6,  11'h400, 4'd1}
};

logic [31:0] pld [MAX_DW];  // payload dws of the current write

// header beat plus one beat per 8 further dws
function automatic int beats_of(input logic [3:0] t, input int n);
    if (t != cq_rx_pkg::REQ_MEM_WR || n <= 4) return 1;
    return 1 + (n - 4 + 7) / 8;
endfunction

// word w holds dw 8w..8w+7, zeros past the length
function automatic cq_rx_pkg::fifo_word_t expect_word(input int w, input int n);
    cq_rx_pkg::fifo_word_t word;
    int                    j;
    word = '0;
    for (j = 0; j < 8; j++) begin
        if (8 * w + j < n) word[j*32 +: 32] = pld[8*w + j];
    end
    return word;
endfunction

function automatic cq_rx_pkg::rd_req_t expect_rd(input logic [10:0] addr, input logic [2:0] tc,
                                                 input logic [2:0] attr, input logic [10:0] len,
                                                 input logic [15:0] rid, input logic [7:0] tag,
                                                 input logic [7:0] be);
    return '{addr, tc, attr, len, rid, tag, be};
endfunction

`endif

// ==== test/cq_rx_engine_tb.sv ====
`timescale 1ns/1ps

module cq_rx_engine_tb;
    localparam int WIN = 64;  // short window for sim

    logic                  clk;
    logic                  rst_n;
    logic                  init_rst_i;
    cq_rx_pkg::cq_beat_t   cq_i;
    logic                  cq_valid_i, cq_tready_o;
    logic                  req_compl_o, compl_done_i;
    cq_rx_pkg::rd_req_t    rd_req_o;
    logic                  fifo_wr_o, pkt_done_o;
    cq_rx_pkg::fifo_word_t fifo_data_o;
    logic                  tput_clear_i, tput_valid_o;
    logic [31:0]           tput_count_o;
    logic                  beat_is_wr;  // bus beat belongs to a write

    int   err_cnt = 0, fail_tests = 0, tput_err = 0;
    int   win_cyc = 0, win_beats = 0, tput_exp = 0, windows_seen = 0, busy_windows = 0;
    logic tput_due = 1'b0;

    `include "cq_rx_cases.svh"

    cq_rx_engine #(.WINDOW_CYCLES(WIN)) uut (
        .clk(clk), .rst_n(rst_n), .init_rst_i(init_rst_i),
        .cq_i(cq_i), .cq_valid_i(cq_valid_i), .cq_tready_o(cq_tready_o),
        .req_compl_o(req_compl_o), .compl_done_i(compl_done_i), .rd_req_o(rd_req_o),
        .fifo_wr_o(fifo_wr_o), .fifo_data_o(fifo_data_o), .pkt_done_o(pkt_done_o),
        .tput_clear_i(tput_clear_i), .tput_count_o(tput_count_o), .tput_valid_o(tput_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns
    end

    ////////////////////
    // throughput model
    ////////////////////
    always @(posedge clk) begin
        if (rst_n) begin
            assert (tput_valid_o == tput_due) else begin
                $display("[FAIL] tput_window valid expected %0b actual %0b",
                         tput_due, tput_valid_o);
                tput_err++;
            end
            if (tput_due) begin
                windows_seen++;
                assert (tput_count_o == 32'(tput_exp)) else begin
                    $display("[FAIL] tput_window expected %0d actual %0d", tput_exp, tput_count_o);
                    tput_err++;
                end
            end
        end
        if (!rst_n || tput_clear_i) begin
            win_cyc   = 0;
            win_beats = 0;
            tput_due  = 1'b0;
        end else begin
            if (cq_valid_i && cq_tready_o && beat_is_wr) win_beats++;  // accepted write beat
            tput_due = (win_cyc == WIN - 1);
            if (tput_due) begin
                tput_exp = win_beats;
                if (win_beats > 0) busy_windows++;
                win_beats = 0;
                win_cyc   = 0;
            end else begin
                win_cyc++;
            end
        end
    end

    function automatic logic [127:0] make_desc(input logic [3:0] t, input logic [10:0] len,
                                               input logic [10:0] addr, input logic [15:0] rid,
                                               input logic [7:0] tag, input logic [2:0] tc,
                                               input logic [2:0] attr);
        logic [127:0] d;
        d          = '0;
        d[12:2]    = addr;
        d[74:64]   = len;
        d[78:75]   = t;
        d[95:80]   = rid;
        d[103:96]  = tag;
        d[123:121] = tc;
        d[126:124] = attr;
        return d;
    endfunction

    // beat k lane j carries dw 8k-4+j
    // header beat keeps the descriptor low and puts noise in payload lanes past the length
    function automatic cq_rx_pkg::cq_beat_t make_beat(input int k, input int n,
                                                     input logic [127:0] desc,
                                                     input logic last, input logic [7:0] be);
        cq_rx_pkg::cq_beat_t b;
        int                  j;
        b = '0;
        for (j = 0; j < 8; j++) begin
            if (8 * k - 4 + j >= 0 && (8 * k - 4 + j < n || k == 0)) begin
                b.data[j*32 +: 32] = pld[8*k - 4 + j];
            end
        end
        if (k == 0) b.data[127:0] = desc;
        b.last = last;
        b.be   = be;
        return b;
    endfunction

    ////////////////////
    // bus tasks
    ////////////////////
    task automatic drive_beat(input cq_rx_pkg::cq_beat_t b, input logic is_wr, output logic ok);
        int waited;
        waited     = 0;
        ok         = 1'b0;
        cq_i       <= b;
        cq_valid_i <= 1'b1;
        beat_is_wr <= is_wr;
        while (!ok && waited < WIN) begin
            @(posedge clk);
            ok = cq_tready_o;  // valid was up so the beat is taken here
            waited++;
        end
        assert (ok) else begin
            $display("stream ready stayed low for %0d cycles", WIN);
            err_cnt++;
        end
    endtask

    task automatic send_write(input int n, input logic [127:0] desc);
        int   k, nb;
        logic ok;
        nb = beats_of(cq_rx_pkg::REQ_MEM_WR, n);
        ok = 1'b1;
        for (k = 0; k < nb && ok; k++) begin
            drive_beat(make_beat(k, n, desc, k == nb - 1, 8'hff), 1'b1, ok);
        end
        cq_valid_i <= 1'b0;
        beat_is_wr <= 1'b0;
    endtask

    task automatic collect_words(input string name, input int n, input int nwords);
        int w, waited;
        w      = 0;
        waited = 0;
        while (w < nwords && waited < WIN) begin
            @(posedge clk);
            waited++;
            if (fifo_wr_o) begin
                assert (fifo_data_o == expect_word(w, n)) else begin
                    $display("[FAIL] %s word %0d expected %h actual %h",
                             name, w, expect_word(w, n), fifo_data_o);
                    err_cnt++;
                end
                assert (pkt_done_o == (w == nwords - 1)) else begin
                    $display("[FAIL] %s pkt_done word %0d expected %0b actual %0b",
                             name, w, w == nwords - 1, pkt_done_o);
                    err_cnt++;
                end
                w++;
            end
        end
        assert (w == nwords) else begin
            $display("%s: only %0d of %0d fifo words arrived", name, w, nwords);
            err_cnt++;
        end
    endtask

    task automatic run_read(input string name, input int n, input logic [10:0] addr);
        logic [15:0]        rid;
        logic [7:0]         tag, be;
        logic [2:0]         tc, attr;
        logic               ok;
        cq_rx_pkg::rd_req_t exp;
        rid  = 16'($urandom);
        tag  = 8'($urandom);
        be   = 8'($urandom);
        tc   = 3'($urandom);
        attr = 3'($urandom);
        exp  = expect_rd(addr, tc, attr, 11'(n), rid, tag, be);
        drive_beat(make_beat(0, 0, make_desc(cq_rx_pkg::REQ_MEM_RD, 11'(n), addr, rid, tag, tc,
                                             attr), 1'b1, be), 1'b0, ok);
        cq_valid_i <= 1'b0;
        if (n == 1) begin
            repeat (3) begin  // held while the completion is pending
                @(posedge clk);
                assert (req_compl_o && !cq_tready_o && rd_req_o == exp) else begin
                    $display("[FAIL] %s expected compl=1 ready=0 req=%h actual %0b %0b %h",
                             name, exp, req_compl_o, cq_tready_o, rd_req_o);
                    err_cnt++;
                end
            end
            compl_done_i <= 1'b1;
            @(posedge clk);
            compl_done_i <= 1'b0;
            @(posedge clk);
            assert (!req_compl_o && cq_tready_o) else begin
                $display("[FAIL] %s after done expected compl=0 ready=1 actual %0b %0b",
                         name, req_compl_o, cq_tready_o);
                err_cnt++;
            end
        end else begin
            repeat (8) begin
                @(posedge clk);
                assert (!req_compl_o) else begin
                    $display("[FAIL] %s req_compl expected 0 actual 1", name);
                    err_cnt++;
                end
            end
        end
    endtask

    task automatic run_case(input int idx);
        case_row_t row;
        int        n, i, errs_before;
        row         = case_tab[idx];
        n           = row.len;
        errs_before = err_cnt;
        if (row.req_type == cq_rx_pkg::REQ_MEM_WR) begin
            for (i = 0; i < MAX_DW; i++) begin
                pld[i] = $urandom;
            end
            fork
                send_write(n, make_desc(row.req_type, row.len, row.addr, 16'($urandom),
                                        8'($urandom), 3'd0, 3'd0));
                collect_words(case_name[idx], n, row.words);
            join
        end else begin
            run_read(case_name[idx], n, row.addr);
        end
        repeat (2) begin  // nothing past the last word
            @(posedge clk);
            assert (!fifo_wr_o) else begin
                $display("%s: unexpected extra fifo word", case_name[idx]);
                err_cnt++;
            end
        end
        if (err_cnt == errs_before) begin
            $display("test %s passed", case_name[idx]);
        end else begin
            $display("test %s failed, %0d check(s)", case_name[idx], err_cnt - errs_before);
            fail_tests++;
        end
    endtask

    task automatic check_tput_clear();
        int waited, errs_before;
        errs_before = err_cnt;
        assert (busy_windows > 0) else begin
            $display("no window with write traffic was reported");
            err_cnt++;
        end
        tput_clear_i <= 1'b1;
        @(posedge clk);
        tput_clear_i <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!tput_valid_o && waited < 2 * WIN);
        assert (tput_valid_o && waited == WIN + 1) else begin
            $display("tput_valid_o expected %0d cycles after clear, seen after %0d",
                     WIN + 1, waited);
            err_cnt++;
        end
        assert (tput_count_o == 32'd0) else begin
            $display("[FAIL] tput_clear expected 0 actual %0d", tput_count_o);
            err_cnt++;
        end
        if (err_cnt == errs_before && tput_err == 0) begin
            $display("test tput passed, %0d windows checked", windows_seen);
        end else begin
            $display("test tput failed, %0d check(s)", err_cnt - errs_before + tput_err);
            fail_tests++;
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial begin : main
        void'($urandom(32'h74f7));
        rst_n        = 1'b0;
        init_rst_i   = 1'b0;
        cq_i         = '0;
        cq_valid_i   = 1'b0;
        beat_is_wr   = 1'b0;
        compl_done_i = 1'b0;
        tput_clear_i = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < NUM_CASES; i++) run_case(i);
        check_tput_clear();
        $display("tests: %0d run, %0d failed, %0d check(s) failed",
                 NUM_CASES + 1, fail_tests, err_cnt + tput_err);
        if (err_cnt == 0 && tput_err == 0 && fail_tests == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // budget from the table plus room for the clear window
    initial begin : watchdog
        int limit;
        limit = 4 + 3 * WIN;
        for (int i = 0; i < NUM_CASES; i++) begin
            limit += beats_of(case_tab[i].req_type, case_tab[i].len) + WIN;
        end
        repeat (limit) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== cq_rx_engine.f ====
+incdir+test
source/cq_rx_pkg.sv
source/cq_rx_fsm.sv
source/wr_dw_counter.sv
source/wr_realign.sv
source/tput_meter.sv
source/cq_rx_engine.sv
test/cq_rx_engine_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cq_rx_engine testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module cq_rx_engine_tb -f cq_rx_engine.f -o sim_cq_rx
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_cq_rx > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
exit 0
